// ==== src/ifu_pkg.sv ====
// Shared fetch unit definitions
// Address, word and parcel types, reset fetch address, parcel helpers
package ifu_pkg;

   // ******************************
   // Types
   // ******************************
   typedef logic [30:0] pc_t;     // Halfword address, byte address bits 31..1
   typedef logic [31:0] word_t;   // One fetched instruction word
   typedef logic [15:0] half_t;   // One instruction parcel

   // ******************************
   // Constants
   // ******************************
   // Fetch starts here after reset, byte address 0x80
   localparam pc_t RESET_PC = 31'h0000_0040;

   // ******************************
   // Helpers
   // ******************************
   // Both low bits set opens a 32-bit instruction
   function automatic logic is_pc4(input half_t parcel);
      return &parcel[1:0];
   endfunction

   // Word address holding this halfword
   function automatic pc_t word_base(input pc_t pc);
      return {pc[30:1], 1'b0};
   endfunction

   // Word address of the following word
   function automatic pc_t next_word(input pc_t pc);
      return {pc[30:1] + 30'd1, 1'b0};
   endfunction

endpackage

// ==== src/ifu_fetch_ctl.sv ====
// Fetch controller
// Fetch address register, four-phase memory handshake, flush epoch
module ifu_fetch_ctl (
   input  logic           clk,
   input  logic           rst_n,
   input  logic           flush,         // Redirect pulse
   input  ifu_pkg::pc_t   flush_pc,      // New fetch halfword
   output logic           imem_req,
   output ifu_pkg::pc_t   imem_addr,     // Word address, bit 0 clear
   input  logic           imem_ack,
   input  ifu_pkg::word_t imem_rdata,
   output ifu_pkg::pc_t   lookup_pc,     // Word address to the BTB
   input  logic           pred_hit,
   input  ifu_pkg::pc_t   pred_target,
   input  logic           has_room,      // Queue can take one more word
   output logic           push,
   output ifu_pkg::word_t push_word,
   output ifu_pkg::pc_t   push_start     // First valid halfword of the word
);
   import ifu_pkg::*;

   typedef enum logic [1:0] {
      ST_IDLE,                           // Req low, ack known low
      ST_REQ,                            // Req high, waiting for ack
      ST_DROP                            // Req dropped, waiting for ack low
   } state_t;

   state_t state;
   pc_t    fetch_pc;                     // Next halfword to fetch
   pc_t    req_pc;                       // Halfword of the request in flight
   logic   epoch;                        // Flips on every flush
   logic   req_epoch;                    // Epoch when the request went out
   logic   capture;
   logic   stale;
   logic   launch;

   // ******************************
   // Handshake decode
   // ******************************
   assign capture = (state == ST_REQ) && imem_ack;       // Data valid this cycle
   assign stale   = flush || (req_epoch != epoch);       // Response predates a flush
   assign launch  = has_room && !flush &&
                    ((state == ST_IDLE) || ((state == ST_DROP) && !imem_ack));

   assign imem_req  = (state == ST_REQ);
   assign imem_addr = word_base(req_pc);                 // Address held while req high
   assign lookup_pc = word_base(req_pc);

   // ******************************
   // Control state
   // ******************************
   always_ff @(posedge clk) begin
      if (!rst_n) begin
         state     <= ST_IDLE;
         fetch_pc  <= RESET_PC;
         epoch     <= 1'b0;
         req_epoch <= 1'b0;
         push      <= 1'b0;
      end else begin
         push <= capture && !stale;                      // Push one cycle after ack
         if (flush) begin
            epoch <= ~epoch;                             // Mark any open request stale
         end
         if (launch) begin
            req_epoch <= epoch;
         end
         // Flush wins over the prediction
         if (flush) begin
            fetch_pc <= flush_pc;
         end else if (capture && !stale) begin
            // Odd target means the next word starts at its upper parcel
            fetch_pc <= pred_hit ? pred_target : next_word(req_pc);
         end
         case (state)
            ST_IDLE: begin
               if (launch) state <= ST_REQ;
            end
            ST_REQ: begin
               if (imem_ack) state <= ST_DROP;           // Capture and drop req
            end
            ST_DROP: begin
               if (!imem_ack) state <= launch ? ST_REQ : ST_IDLE;
            end
            default: state <= ST_IDLE;
         endcase
      end
   end

   // Request address and captured word
   always_ff @(posedge clk) begin
      if (launch) begin
         req_pc <= fetch_pc;                             // Stable for the whole request
      end
      if (capture) begin
         push_word  <= imem_rdata;
         push_start <= req_pc;                           // Redirect target or word start
      end
   end

endmodule

// ==== src/ifu_btb.sv ====
// Direct-mapped branch target buffer
// Combinational lookup, write or clear from execute
module ifu_btb #(
   parameter int BTB_DEPTH = 16                   // Entries, power of two
) (
   input  logic         clk,
   input  logic         rst_n,
   input  ifu_pkg::pc_t lookup_pc,               // Word address being fetched
   output logic         pred_hit,
   output ifu_pkg::pc_t pred_target,
   input  logic         upd_valid,               // One-cycle update pulse
   input  ifu_pkg::pc_t upd_pc,                  // Word address of the branch word
   input  ifu_pkg::pc_t upd_target,
   input  logic         upd_taken                // Taken writes, not taken clears
);
   import ifu_pkg::*;

   localparam int IDX_W = $clog2(BTB_DEPTH);
   localparam int TAG_W = 30 - IDX_W;            // Bits above the index

   logic [BTB_DEPTH-1:0] btb_valid;
   logic [TAG_W-1:0]     btb_tag    [BTB_DEPTH];
   pc_t                  btb_target [BTB_DEPTH];
   logic [IDX_W-1:0]     lk_idx;
   logic [IDX_W-1:0]     up_idx;
   logic                 up_match;

   // ******************************
   // Lookup
   // ******************************
   assign lk_idx      = lookup_pc[IDX_W:1];      // Low word address bits
   assign up_idx      = upd_pc[IDX_W:1];
   assign pred_hit    = btb_valid[lk_idx] && (btb_tag[lk_idx] == lookup_pc[30:IDX_W+1]);
   assign pred_target = btb_target[lk_idx];
   assign up_match    = btb_valid[up_idx] && (btb_tag[up_idx] == upd_pc[30:IDX_W+1]);

   // ******************************
   // Update
   // ******************************
   always_ff @(posedge clk) begin
      if (!rst_n) begin
         btb_valid <= '0;
      end else if (upd_valid) begin
         if (upd_taken) begin
            btb_valid[up_idx] <= 1'b1;
         end else if (up_match) begin
            btb_valid[up_idx] <= 1'b0;           // Clear only our own branch
         end
      end
   end

   always_ff @(posedge clk) begin
      if (upd_valid && upd_taken) begin
         btb_tag[up_idx]    <= upd_pc[30:IDX_W+1];
         btb_target[up_idx] <= upd_target;       // Halfword aligned target allowed
      end
   end

endmodule

// ==== src/ifu_fetch_queue.sv ====
// Fetch queue
// Circular buffer of words and start halfwords, room flag
module ifu_fetch_queue #(
   parameter int QUEUE_DEPTH = 4                 // Words held
) (
   input  logic           clk,
   input  logic           rst_n,
   input  logic           flush,                 // Empties the buffer
   input  logic           push,
   input  ifu_pkg::word_t push_word,
   input  ifu_pkg::pc_t   push_start,
   output logic           has_room,              // Safe to start another fetch
   input  logic           pop,
   output logic           q_valid,
   output ifu_pkg::word_t q_word,
   output ifu_pkg::pc_t   q_start
);
   import ifu_pkg::*;

   localparam int PTR_W = (QUEUE_DEPTH > 1) ? $clog2(QUEUE_DEPTH) : 1;
   localparam int CNT_W = $clog2(QUEUE_DEPTH + 1);

   word_t            mem_word  [QUEUE_DEPTH];
   pc_t              mem_start [QUEUE_DEPTH];
   logic [PTR_W-1:0] wr_ptr;
   logic [PTR_W-1:0] rd_ptr;
   logic [CNT_W-1:0] count;
   logic             do_push;
   logic             do_pop;

   // Pointer step with wrap for any depth
   function automatic logic [PTR_W-1:0] ptr_inc(input logic [PTR_W-1:0] ptr);
      return (int'(ptr) == QUEUE_DEPTH - 1) ? '0 : ptr + 1'b1;
   endfunction

   assign do_push  = push && !flush;
   assign do_pop   = pop && q_valid && !flush;
   assign q_valid  = (count != '0);
   assign q_word   = mem_word[rd_ptr];
   assign q_start  = mem_start[rd_ptr];
   // Word being pushed counts as taken, plus room for one in flight
   assign has_room = (int'(count) + int'(push)) < QUEUE_DEPTH;

   // ******************************
   // Pointers and count
   // ******************************
   always_ff @(posedge clk) begin
      if (!rst_n || flush) begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         count  <= '0;
      end else begin
         if (do_push) wr_ptr <= ptr_inc(wr_ptr);
         if (do_pop)  rd_ptr <= ptr_inc(rd_ptr);
         if (do_push && !do_pop) begin
            count <= count + 1'b1;
         end else if (do_pop && !do_push) begin
            count <= count - 1'b1;
         end
      end
   end

   always_ff @(posedge clk) begin
      if (do_push) begin
         mem_word[wr_ptr]  <= push_word;
         mem_start[wr_ptr] <= push_start;        // Visible to the aligner next cycle
      end
   end

endmodule

// ==== src/ifu_aligner.sv ====
// Aligner
// Parcel staging, instruction length decode, decode valid/ready port
module ifu_aligner (
   input  logic           clk,
   input  logic           rst_n,
   input  logic           flush,                  // Drop staged and output instruction
   input  logic           q_valid,
   input  ifu_pkg::word_t q_word,
   input  ifu_pkg::pc_t   q_start,                // First valid halfword of q_word
   output logic           pop,
   output logic           i0_valid,
   input  logic           i0_ready,
   output ifu_pkg::word_t i0_instr,
   output ifu_pkg::pc_t   i0_pc,
   output logic           i0_pc4                  // 32-bit instruction
);
   import ifu_pkg::*;

   half_t      par     [3];                       // Staged parcels, oldest first
   pc_t        par_pc  [3];
   half_t      sh_par  [3];                       // After consumed parcels leave
   pc_t        sh_pc   [3];
   half_t      par_nxt [3];
   pc_t        pc_nxt  [3];
   logic [1:0] cnt;                               // Parcels staged
   logic [1:0] cnt_left;
   logic [1:0] n_cons;
   logic [1:0] n_word;                            // Parcels the head word brings
   logic       first_pc4;
   logic       inst_rdy;
   logic       out_free;
   logic       load;
   half_t      w_lo;
   half_t      w_hi;
   pc_t        w_lo_pc;
   pc_t        w_hi_pc;

   // ******************************
   // Length decode and pop
   // ******************************
   assign first_pc4 = is_pc4(par[0]);
   assign inst_rdy  = (cnt != 2'd0) && (!first_pc4 || (cnt >= 2'd2));
   assign out_free  = !i0_valid || i0_ready;      // Output empty or leaving
   assign load      = out_free && inst_rdy && !flush;
   assign n_cons    = !load ? 2'd0 : (first_pc4 ? 2'd2 : 2'd1);
   assign cnt_left  = cnt - n_cons;
   assign n_word    = q_start[0] ? 2'd1 : 2'd2;   // Odd start skips the low parcel
   assign pop       = q_valid && !flush && (({1'b0, cnt_left} + {1'b0, n_word}) <= 3'd3);

   assign w_lo    = q_start[0] ? q_word[31:16] : q_word[15:0];
   assign w_hi    = q_word[31:16];
   assign w_lo_pc = q_start;
   assign w_hi_pc = {q_start[30:1], 1'b1};

   // Shift out what goes to the output
   always_comb begin
      sh_par = par;
      sh_pc  = par_pc;
      if (n_cons == 2'd1) begin
         sh_par[0] = par[1];
         sh_par[1] = par[2];
         sh_pc[0]  = par_pc[1];
         sh_pc[1]  = par_pc[2];
      end else if (n_cons == 2'd2) begin
         sh_par[0] = par[2];
         sh_pc[0]  = par_pc[2];
      end
   end

   // Append the popped word behind the leftovers
   always_comb begin
      par_nxt = sh_par;
      pc_nxt  = sh_pc;
      if (pop) begin
         for (int i = 0; i < 3; i++) begin
            if (i == int'(cnt_left)) begin
               par_nxt[i] = w_lo;
               pc_nxt[i]  = w_lo_pc;
            end else if ((n_word == 2'd2) && (i == int'(cnt_left) + 1)) begin
               par_nxt[i] = w_hi;
               pc_nxt[i]  = w_hi_pc;
            end
         end
      end
   end

   // ******************************
   // Staging and output registers
   // ******************************
   always_ff @(posedge clk) begin
      if (!rst_n || flush) begin
         cnt      <= 2'd0;
         i0_valid <= 1'b0;
      end else begin
         cnt <= cnt_left + (pop ? n_word : 2'd0);   // Never above three
         if (out_free) i0_valid <= inst_rdy;        // Hold under back-pressure
      end
   end

   always_ff @(posedge clk) begin
      par    <= par_nxt;
      par_pc <= pc_nxt;
      if (load) begin
         i0_instr <= first_pc4 ? {par[1], par[0]} : {16'h0000, par[0]};
         i0_pc    <= par_pc[0];                     // Address of the first parcel
         i0_pc4   <= first_pc4;
      end
   end

endmodule

// ==== src/ifu_top.sv ====
// Instruction fetch unit top level
// Fetch controller, BTB, fetch queue and aligner
module ifu_top #(
   parameter int BTB_DEPTH   = 16,              // BTB entries
   parameter int QUEUE_DEPTH = 4                // Fetch queue words
) (
   input  logic           clk,
   input  logic           rst_n,
   input  logic           flush,
   input  ifu_pkg::pc_t   flush_pc,
   output logic           imem_req,
   output ifu_pkg::pc_t   imem_addr,
   input  logic           imem_ack,
   input  ifu_pkg::word_t imem_rdata,
   input  logic           upd_valid,
   input  ifu_pkg::pc_t   upd_pc,
   input  ifu_pkg::pc_t   upd_target,
   input  logic           upd_taken,
   output logic           i0_valid,
   input  logic           i0_ready,
   output ifu_pkg::word_t i0_instr,
   output ifu_pkg::pc_t   i0_pc,
   output logic           i0_pc4
);
   import ifu_pkg::*;

   pc_t   lookup_pc;
   logic  pred_hit;
   pc_t   pred_target;
   logic  has_room;
   logic  push;
   word_t push_word;
   pc_t   push_start;
   logic  pop;
   logic  q_valid;
   word_t q_word;
   pc_t   q_start;

   // ******************************
   // Fetch side
   // ******************************
   ifu_fetch_ctl ifc (
      .clk(clk), .rst_n(rst_n), .flush(flush), .flush_pc(flush_pc),
      .imem_req(imem_req), .imem_addr(imem_addr), .imem_ack(imem_ack),
      .imem_rdata(imem_rdata), .lookup_pc(lookup_pc), .pred_hit(pred_hit),
      .pred_target(pred_target), .has_room(has_room), .push(push),
      .push_word(push_word), .push_start(push_start)
   );

   ifu_btb #(.BTB_DEPTH(BTB_DEPTH)) btb (
      .clk(clk), .rst_n(rst_n), .lookup_pc(lookup_pc), .pred_hit(pred_hit),
      .pred_target(pred_target), .upd_valid(upd_valid), .upd_pc(upd_pc),
      .upd_target(upd_target), .upd_taken(upd_taken)
   );

   // ******************************
   // Queue and decode side
   // ******************************
   ifu_fetch_queue #(.QUEUE_DEPTH(QUEUE_DEPTH)) fq (
      .clk(clk), .rst_n(rst_n), .flush(flush), .push(push),
      .push_word(push_word), .push_start(push_start), .has_room(has_room),
      .pop(pop), .q_valid(q_valid), .q_word(q_word), .q_start(q_start)
   );

   ifu_aligner aln (
      .clk(clk), .rst_n(rst_n), .flush(flush), .q_valid(q_valid),
      .q_word(q_word), .q_start(q_start), .pop(pop), .i0_valid(i0_valid),
      .i0_ready(i0_ready), .i0_instr(i0_instr), .i0_pc(i0_pc), .i0_pc4(i0_pc4)
   );

endmodule

// ==== bench/ifu_properties.sv ====
// Bound checks for the fetch unit
// Memory handshake rules and decode output hold under back-pressure
module ifu_properties (
   input logic           clk,
   input logic           rst_n,
   input logic           flush,
   input logic           imem_req,
   input logic           imem_ack,
   input logic           i0_valid,
   input logic           i0_ready,
   input ifu_pkg::word_t i0_instr,
   input ifu_pkg::pc_t   i0_pc,
   input logic           i0_pc4
);
   timeunit 1ns;
   timeprecision 1ps;

   int unsigned fail_count = 0;                   // Read by the testbench

   // Request stays up until the memory answers
   req_hold: assert property (@(posedge clk) disable iff (!rst_n)
      imem_req && !imem_ack |=> imem_req)
      else begin fail_count++; $error("imem_req dropped before imem_ack"); end

   // No new request while the old ack is still high
   req_after_ack: assert property (@(posedge clk) disable iff (!rst_n)
      !imem_req && imem_ack |=> !imem_req)
      else begin fail_count++; $error("imem_req rose while imem_ack was high"); end

   // Stalled instruction holds unless flushed
   out_hold: assert property (@(posedge clk) disable iff (!rst_n)
      i0_valid && !i0_ready && !flush |=>
         i0_valid && $stable(i0_instr) && $stable(i0_pc) && $stable(i0_pc4))
      else begin fail_count++; $error("decode output changed while stalled"); end

endmodule

// ==== bench/ifu_tb.sv ====
// Fetch unit testbench
// Clock, reset, memory responder, reference stream, compare tasks, test sequence
module ifu_tb;
   timeunit 1ns;
   timeprecision 1ps;
   import ifu_pkg::*;

   localparam logic [31:0] SEED = 32'h7d26;
   localparam int BTB_DEPTH  = 16;
   localparam int IDX_W      = $clog2(BTB_DEPTH);
   localparam int MEM_WORDS  = 512;                // Indexed by halfword bits 9..1
   localparam pc_t FLUSH_PC  = 31'h0000_0151;      // Odd, upper parcel opens a 32-bit
   localparam int TIMEOUT    = 2000;
   localparam int ACK_LIMIT  = 100;
   localparam int IDLE_LIMIT = 1000;

   logic clk, rst_n, flush, imem_req, imem_ack, upd_valid, upd_taken;
   logic i0_valid, i0_ready, i0_pc4, ready_en;
   pc_t  flush_pc, imem_addr, upd_pc, upd_target, i0_pc, restart_pc;
   word_t imem_rdata, i0_instr;
   word_t mem_image [MEM_WORDS];
   logic model_valid [BTB_DEPTH];                  // BTB contents as written by the test
   pc_t  model_addr  [BTB_DEPTH];
   pc_t  model_tgt   [BTB_DEPTH];
   logic [31:0] drv_rng;
   int   flush_seq = 0;                            // Bumped on each flush
   int   xfer_count = 0;

   ifu_top #(.BTB_DEPTH(BTB_DEPTH), .QUEUE_DEPTH(4)) UUT (
      .clk(clk), .rst_n(rst_n), .flush(flush), .flush_pc(flush_pc),
      .imem_req(imem_req), .imem_addr(imem_addr), .imem_ack(imem_ack),
      .imem_rdata(imem_rdata), .upd_valid(upd_valid), .upd_pc(upd_pc),
      .upd_target(upd_target), .upd_taken(upd_taken), .i0_valid(i0_valid),
      .i0_ready(i0_ready), .i0_instr(i0_instr), .i0_pc(i0_pc), .i0_pc4(i0_pc4)
   );

   bind ifu_top ifu_properties props (
      .clk(clk), .rst_n(rst_n), .flush(flush), .imem_req(imem_req),
      .imem_ack(imem_ack), .i0_valid(i0_valid), .i0_ready(i0_ready),
      .i0_instr(i0_instr), .i0_pc(i0_pc), .i0_pc4(i0_pc4)
   );

   initial begin
      clk = 1'b0;
      forever #5 clk = ~clk;                       // 10 ns period
   end

   // ******************************
   // Helpers and reference model
   // ******************************
   function automatic logic [31:0] xorshift(input logic [31:0] s);
      logic [31:0] x;
      x = s;
      x = x ^ (x << 13);
      x = x ^ (x >> 17);
      x = x ^ (x << 5);
      return x;
   endfunction

   function automatic half_t parcel_at(input pc_t h);
      word_t w;
      w = mem_image[h[9:1]];
      return h[0] ? w[31:16] : w[15:0];
   endfunction

   // Next parcel in the fetched stream
   function automatic pc_t next_parcel(input pc_t h);
      pc_t w;
      logic [IDX_W-1:0] idx;
      w   = {h[30:1], 1'b0};
      idx = w[IDX_W:1];
      if (!h[0]) return h + 31'd1;                 // Upper half of the same word
      if (model_valid[idx] && (model_addr[idx] == w)) return model_tgt[idx];
      return w + 31'd2;
   endfunction

   // Expected instruction at pc and the pc of the one after it
   function automatic word_t ref_instr(input pc_t pc, output pc_t after, output logic pc4);
      half_t p0;
      half_t p1;
      pc_t   p1_pc;
      p0    = parcel_at(pc);
      p1_pc = next_parcel(pc);
      pc4   = (p0[1:0] == 2'b11);
      if (!pc4) begin
         after = p1_pc;
         return {16'h0000, p0};
      end
      p1    = parcel_at(p1_pc);                    // May come from a branch target
      after = next_parcel(p1_pc);
      return {p1, p0};
   endfunction

   task automatic fail_run();
      $display("TESTS FAILED");
      $fatal(1, "simulation stopped on a failed check");
   endtask

   task automatic check_pc(input string what, input pc_t got, input pc_t exp);
      if (got !== exp) begin
         $display("ERROR at %0t ns: %s is %h, expected %h", $time, what, got, exp);
         fail_run();
      end
   endtask

   task automatic check_instr(input string what, input word_t got, input word_t exp);
      if (got !== exp) begin
         $display("ERROR at %0t ns: %s is %h, expected %h", $time, what, got, exp);
         fail_run();
      end
   endtask

   task automatic check_flag(input string what, input logic got, input logic exp);
      if (got !== exp) begin
         $display("ERROR at %0t ns: %s is %b, expected %b", $time, what, got, exp);
         fail_run();
      end
   endtask

   task automatic fill_memory();
      logic [31:0] s;
      s = SEED;
      for (int i = 0; i < MEM_WORDS; i++) begin
         s = xorshift(s);
         mem_image[i] = s;
      end
      mem_image[RESET_PC[9:1]][1:0]   = 2'b01;     // 16-bit first, then a straddler
      mem_image[RESET_PC[9:1]][17:16] = 2'b11;
      mem_image[FLUSH_PC[9:1]][17:16] = 2'b11;     // Straddles right after the flush
   endtask

   // ******************************
   // Stimulus tasks
   // ******************************
   task automatic step();
      @(posedge clk);
      #1;
      flush     = 1'b0;
      upd_valid = 1'b0;
      drv_rng   = xorshift(drv_rng);
      i0_ready  = ready_en && (drv_rng[1:0] != 2'b00);   // About 3 of 4 cycles
   endtask

   task automatic wait_transfers(input int n);
      int target;
      int waited;
      target = xfer_count + n;
      waited = 0;
      while (xfer_count < target) begin
         step();
         waited++;
         if (waited > TIMEOUT) begin
            $display("Timed out waiting for %0d instructions at decode", n);
            fail_run();
         end
      end
   endtask

   task automatic wait_request();
      int waited;
      waited = 0;
      while (!imem_req) begin
         step();
         waited++;
         if (waited > TIMEOUT) begin
            $display("Timed out waiting for a memory request");
            fail_run();
         end
      end
   endtask

   task automatic flush_to(input pc_t pc);
      flush      = 1'b1;
      flush_pc   = pc;
      i0_ready   = 1'b0;                           // Nothing leaves in the flush cycle
      restart_pc = pc;
      flush_seq++;
      step();
   endtask

   task automatic btb_update(input pc_t pc, input pc_t target, input logic taken);
      logic [IDX_W-1:0] idx;
      idx        = pc[IDX_W:1];
      upd_valid  = 1'b1;
      upd_pc     = pc;
      upd_target = target;
      upd_taken  = taken;
      if (taken) begin
         model_valid[idx] = 1'b1;
         model_addr[idx]  = pc;
         model_tgt[idx]   = target;
      end else if (model_valid[idx] && (model_addr[idx] == pc)) begin
         model_valid[idx] = 1'b0;
      end
      step();
   endtask

   // ******************************
   // Memory responder
   // ******************************
   initial begin : mem_responder
      logic [31:0] rng;
      int waited;
      int idle;
      imem_ack   = 1'b0;
      imem_rdata = '0;
      rng        = SEED ^ 32'h0000_5a5a;
      idle       = 0;
      forever begin
         @(posedge clk);
         #1;
         if (rst_n && imem_req) begin
            idle = 0;
            rng  = xorshift(rng);
            repeat (int'(rng[1:0])) begin
               @(posedge clk);
               #1;
            end
            check_flag("imem_addr bit 0", imem_addr[0], 1'b0);   // Word address only
            imem_rdata = mem_image[imem_addr[9:1]];
            imem_ack   = 1'b1;
            waited     = 0;
            while (imem_req) begin                 // Controller drops req on capture
               @(posedge clk);
               #1;
               waited++;
               if (waited > ACK_LIMIT) begin
                  $display("Memory request stayed high after acknowledge");
                  fail_run();
               end
            end
            rng = xorshift(rng);
            repeat (int'(rng[1:0])) begin
               @(posedge clk);
               #1;
            end
            imem_ack = 1'b0;
         end else if (rst_n) begin
            idle++;
            if (idle > IDLE_LIMIT) begin
               $display("No memory request for %0d cycles", IDLE_LIMIT);
               fail_run();
            end
         end
      end
   end

   // ******************************
   // Compare process
   // ******************************
   initial begin : compare_proc
      pc_t   exp_pc;
      pc_t   exp_after;
      word_t exp_instr;
      logic  exp_pc4;
      int    seen_seq;
      exp_pc   = RESET_PC;
      seen_seq = 0;
      forever begin
         @(negedge clk);                            // Valid, ready and data settled
         if (UUT.props.fail_count != 0) begin
            $display("A bound assertion on the DUT failed");
            fail_run();
         end
         if (flush_seq != seen_seq) begin
            exp_pc   = restart_pc;
            seen_seq = flush_seq;
         end
         if (rst_n && i0_valid && i0_ready) begin
            exp_instr = ref_instr(exp_pc, exp_after, exp_pc4);
            check_pc("i0_pc", i0_pc, exp_pc);
            check_instr("i0_instr", i0_instr, exp_instr);
            check_flag("i0_pc4", i0_pc4, exp_pc4);
            exp_pc = exp_after;
            xfer_count++;
         end
      end
   end

   // ******************************
   // Test sequence
   // ******************************
   initial begin : main_seq
      rst_n      = 1'b0;
      flush      = 1'b0;
      flush_pc   = '0;
      upd_valid  = 1'b0;
      upd_pc     = '0;
      upd_target = '0;
      upd_taken  = 1'b0;
      i0_ready   = 1'b0;
      restart_pc = RESET_PC;
      ready_en   = 1'b1;
      drv_rng    = SEED;
      for (int i = 0; i < BTB_DEPTH; i++) model_valid[i] = 1'b0;
      fill_memory();
      repeat (3) step();                            // Reset held for 3 cycles
      rst_n = 1'b1;
      check_flag("imem_req after reset", imem_req, 1'b0);
      check_flag("i0_valid after reset", i0_valid, 1'b0);
      wait_transfers(60);                           // Sequential stream from reset
      wait_request();
      flush_to(FLUSH_PC);                           // Flush with a request open
      wait_transfers(40);
      ready_en = 1'b0;                              // Quiet decode before BTB writes
      step();
      btb_update(31'h0000_00a0, 31'h0000_00c1, 1'b1);   // Odd target
      btb_update(31'h0000_00c4, 31'h0000_00a0, 1'b1);
      ready_en = 1'b1;
      flush_to(31'h0000_00a0);
      wait_transfers(40);
      ready_en = 1'b0;
      step();
      btb_update(31'h0000_00a0, 31'h0000_0000, 1'b0);   // Clears the first entry
      ready_en = 1'b1;
      flush_to(31'h0000_00a0);
      wait_transfers(40);
      $display("TESTS PASSED");
      $finish;
   end

endmodule

// ==== sources.f ====
src/ifu_pkg.sv
src/ifu_fetch_ctl.sv
src/ifu_btb.sv
src/ifu_fetch_queue.sv
src/ifu_aligner.sv
src/ifu_top.sv
bench/ifu_properties.sv
bench/ifu_tb.sv

// ==== Makefile ====
# Verilator build and run of the fetch unit testbench
TOP := ifu_tb

all: run

build:
	verilator --binary --assert --timescale 1ns/1ps --top-module $(TOP) -f sources.f -Mdir obj_dir

run: build
	obj_dir/V$(TOP) +verilator+error+limit+100

lint:
	verilator --lint-only -Wall --timing --assert --timescale 1ns/1ps --top-module $(TOP) -f sources.f

clean:
	rm -rf obj_dir

.PHONY: all build run lint clean
